/* accel_top.f */
rtl/accel_pkg.sv
rtl/cmd_parser.sv
rtl/cmd_exec.sv
rtl/reply_builder.sv
rtl/accel_top.sv
tb/accel_top_tb.sv

/* Bender.yml */
package:
  name: accel_top

sources:
  - rtl/accel_pkg.sv
  - rtl/cmd_parser.sv
  - rtl/cmd_exec.sv
  - rtl/reply_builder.sv
  - rtl/accel_top.sv
  - target: test
    files:
      - tb/accel_top_tb.sv

/* tb/accel_top_tb.sv */
/*
  Testbench for accel_top with a packet table and expected replies, a stream
  driver, reply capture under random back-pressure, and a cycle timeout
*/

`timescale 1ns/1ns

module accel_top_tb
  import accel_pkg::*;
();

  localparam int NUM_PKTS  = 12;
  localparam int MAX_WORDS = 6;

  typedef struct packed {
    logic [7:0]                 opcode;
    logic [7:0]                 tag;
    logic [2:0]                 len;        // Payload words, 0 to 6
    logic [MAX_WORDS-1:0][63:0] words;
    logic [63:0]                exp_head;   // Expected reply header word
    logic [63:0]                exp_value;
  } pkt_entry_t;

  logic         i_clk_100 = 1'b0;
  logic         i_rst;
  stream_word_t i_rx;
  logic         i_rx_valid;
  logic         o_rx_ready;
  stream_word_t o_tx;
  logic         o_tx_valid;
  logic         i_tx_ready;

  pkt_entry_t   pkt_tab [NUM_PKTS];
  stream_word_t reply_q [$];                // Reply beats in arrival order
  integer       seed = 32'hcbe7;
  int           timeout_limit = 0;
  int           cycle_cnt = 0;

  accel_top i_dut (
    .i_clk_100  ( i_clk_100  ),
    .i_rst      ( i_rst      ),
    .i_rx       ( i_rx       ),
    .i_rx_valid ( i_rx_valid ),
    .o_rx_ready ( o_rx_ready ),
    .o_tx       ( o_tx       ),
    .o_tx_valid ( o_tx_valid ),
    .i_tx_ready ( i_tx_ready )
  );

  always #4 i_clk_100 = ~i_clk_100;

  // Output ready drops on about a quarter of the cycles
  always @(posedge i_clk_100)
    i_tx_ready <= (($random(seed) & 3) != 0);

  // Valid and ready are steady at the falling edge
  always @(negedge i_clk_100)
    if (!i_rst && o_tx_valid && i_tx_ready)
      reply_q.push_back(o_tx);

  always @(posedge i_clk_100) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_limit) begin
      $display("Timeout after %0d cycles, the replies did not all arrive", cycle_cnt);
      $display("TEST FAILED");
      $fatal(1, "Timeout");
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic set_entry(input int idx, input logic [7:0] opcode,
                           input logic [7:0] tag, input int len);
    pkt_tab[idx].opcode = opcode;
    pkt_tab[idx].tag    = tag;
    pkt_tab[idx].len    = 3'(len);
    for (int j = 0; j < MAX_WORDS; j++)
      pkt_tab[idx].words[j] = {$random(seed), $random(seed)};
  endtask

  // Reference model of the engine with one reply per table entry
  task automatic build_expected();
    logic [63:0] sum;
    logic [63:0] xr;
    logic [63:0] value;
    logic [7:0]  status;
    logic [63:0] done_cnt;
    int          beats;
    done_cnt = 64'd0;
    beats    = 0;
    for (int i = 0; i < NUM_PKTS; i++) begin
      sum = 64'd0;
      xr  = 64'd0;
      for (int j = 0; j < pkt_tab[i].len; j++) begin
        sum = sum + pkt_tab[i].words[j];    // Wraps modulo 2^64
        xr  = xr ^ pkt_tab[i].words[j];
      end
      status = ST_OK;
      case (pkt_tab[i].opcode)
        OP_SUM:    value = sum;
        OP_XOR:    value = xr;
        OP_STATUS: value = done_cnt;        // Packets before this one
        OP_CLEAR:  value = 64'd0;
        default: begin
          value  = 64'd0;
          status = ST_BAD_OPCODE;
        end
      endcase
      done_cnt = (pkt_tab[i].opcode == OP_CLEAR) ? 64'd0 : done_cnt + 64'd1;
      pkt_tab[i].exp_value = value;
      pkt_tab[i].exp_head  = {24'd0, 16'(pkt_tab[i].len), status,
                              pkt_tab[i].tag, pkt_tab[i].opcode};
      beats += 1 + pkt_tab[i].len;
    end
    timeout_limit = 20 * beats + 100;
  endtask

  // Holds the beat until the rising edge where ready is high
  task automatic send_beat(input logic [63:0] data, input logic last);
    logic taken;
    i_rx.data  <= data;
    i_rx.last  <= last;
    i_rx_valid <= 1'b1;
    do begin
      @(negedge i_clk_100);
      taken = o_rx_ready;
      @(posedge i_clk_100);
    end while (!taken);
  endtask

  task automatic send_packet(input int idx);
    logic [63:0] head;
    // Upper header bits carry junk that the parser ignores
    head = {8'(idx) * 8'h3b, 40'h5a_0000_00c3, pkt_tab[idx].tag, pkt_tab[idx].opcode};
    send_beat(head, pkt_tab[idx].len == 0);
    for (int j = 0; j < pkt_tab[idx].len; j++)
      send_beat(pkt_tab[idx].words[j], j == pkt_tab[idx].len - 1);
  endtask

  initial begin
    i_rst      = 1'b1;
    i_rx       = '0;
    i_rx_valid = 1'b0;
    i_tx_ready = 1'b0;

    set_entry(0,  OP_STATUS, 8'h10, 0);
    set_entry(1,  OP_SUM,    8'h11, 4);
    set_entry(2,  OP_SUM,    8'h12, 3);
    set_entry(3,  OP_XOR,    8'h13, 5);
    set_entry(4,  OP_XOR,    8'h14, 0);
    set_entry(5,  OP_SUM,    8'h15, 0);
    set_entry(6,  OP_STATUS, 8'h16, 2);
    set_entry(7,  OP_CLEAR,  8'h17, 1);
    set_entry(8,  OP_STATUS, 8'h18, 0);
    set_entry(9,  8'h7f,     8'h19, 3);     // Unknown opcode
    set_entry(10, OP_SUM,    8'h1a, 6);
    set_entry(11, OP_STATUS, 8'h1b, 0);
    // Carries out of bit 63
    pkt_tab[2].words[0] = 64'hffff_ffff_ffff_fff0;
    pkt_tab[2].words[1] = 64'hffff_ffff_ffff_ffff;
    pkt_tab[2].words[2] = 64'h8000_0000_0000_0123;
    build_expected();

    repeat (4) @(posedge i_clk_100);
    i_rst <= 1'b0;
    @(negedge i_clk_100);
    check_value("o_rx_ready", o_rx_ready, 64'd1);   // Ready for a header out of reset
    check_value("o_tx_valid", o_tx_valid, 64'd0);
    @(posedge i_clk_100);
    for (int i = 0; i < NUM_PKTS; i++)
      send_packet(i);
    i_rx_valid <= 1'b0;

    wait (reply_q.size() >= 2 * NUM_PKTS);
    repeat (20) @(posedge i_clk_100);       // Room for any stray extra beat
    check_value("reply beat count", reply_q.size(), 2 * NUM_PKTS);
    for (int i = 0; i < NUM_PKTS; i++) begin
      check_value($sformatf("o_tx.data header %0d", i), reply_q[2*i].data,
                  pkt_tab[i].exp_head);
      check_value($sformatf("o_tx.last header %0d", i), reply_q[2*i].last, 64'd0);
      check_value($sformatf("o_tx.data value %0d", i), reply_q[2*i+1].data,
                  pkt_tab[i].exp_value);
      check_value($sformatf("o_tx.last value %0d", i), reply_q[2*i+1].last, 64'd1);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

/* rtl/accel_top.sv */
/*
  Command engine top level: parser, executor and reply builder in series
*/

`timescale 1ns/1ns

module accel_top
  import accel_pkg::*;
(
  input  logic         i_clk_100,
  input  logic         i_rst,
  input  stream_word_t i_rx,
  input  logic         i_rx_valid,
  output logic         o_rx_ready,
  output stream_word_t o_tx,
  output logic         o_tx_valid,
  input  logic         i_tx_ready
);

  exec_beat_t beat;
  logic       beat_valid;
  logic       beat_ready;
  result_t    res;
  logic       res_valid;
  logic       res_ready;

  cmd_parser u_cmd_parser (
    .i_clk_100    ( i_clk_100  ),
    .i_rst        ( i_rst      ),
    .i_rx         ( i_rx       ),
    .i_rx_valid   ( i_rx_valid ),
    .o_rx_ready   ( o_rx_ready ),
    .o_beat       ( beat       ),
    .o_beat_valid ( beat_valid ),
    .i_beat_ready ( beat_ready )
  );

  cmd_exec u_cmd_exec (
    .i_clk_100    ( i_clk_100  ),
    .i_rst        ( i_rst      ),
    .i_beat       ( beat       ),
    .i_beat_valid ( beat_valid ),
    .o_beat_ready ( beat_ready ),
    .o_res        ( res        ),
    .o_res_valid  ( res_valid  ),
    .i_res_ready  ( res_ready  )
  );

  reply_builder u_reply_builder (
    .i_clk_100   ( i_clk_100  ),
    .i_rst       ( i_rst      ),
    .i_res       ( res        ),
    .i_res_valid ( res_valid  ),
    .o_res_ready ( res_ready  ),
    .o_tx        ( o_tx       ),
    .o_tx_valid  ( o_tx_valid ),
    .i_tx_ready  ( i_tx_ready )
  );

endmodule

/* rtl/reply_builder.sv */
/*
  Reply serializer: latches one result and sends it as a header word
  followed by the result word on the output stream
*/

`timescale 1ns/1ns

module reply_builder
  import accel_pkg::*;
(
  input  logic         i_clk_100,
  input  logic         i_rst,
  input  result_t      i_res,
  input  logic         i_res_valid,
  output logic         o_res_ready,
  output stream_word_t o_tx,
  output logic         o_tx_valid,
  input  logic         i_tx_ready
);

  typedef enum logic [1:0] {
    R_IDLE,
    R_HEAD,
    R_VALUE
  } state_e;

  state_e               state;
  result_t              res_q;
  logic [WORD_BITS-1:0] head_word;

  assign o_res_ready = (state == R_IDLE);

  // Opcode, tag, status and count packed from the low end, rest zero
  assign head_word = {24'd0, res_q.count, res_q.status, res_q.tag, res_q.opcode};

  assign o_tx_valid = (state != R_IDLE);
  assign o_tx.data  = (state == R_VALUE) ? res_q.value : head_word;
  assign o_tx.last  = (state == R_VALUE);

  always_ff @(posedge i_clk_100) begin
    if (i_rst) begin
      state <= R_IDLE;
    end else begin
      case (state)
        R_IDLE:  if (i_res_valid) state <= R_HEAD;
        R_HEAD:  if (i_tx_ready) state <= R_VALUE;
        R_VALUE: if (i_tx_ready) state <= R_IDLE;   // Reply done
        default: state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk_100) begin
    if (o_res_ready && i_res_valid)
      res_q <= i_res;
  end

endmodule

/* rtl/cmd_exec.sv */
/*
  Command executor: per-packet sum, XOR and word count, the packet
  completion counter, and one result per packet
*/

`timescale 1ns/1ns

module cmd_exec
  import accel_pkg::*;
(
  input  logic       i_clk_100,
  input  logic       i_rst,
  input  exec_beat_t i_beat,
  input  logic       i_beat_valid,
  output logic       o_beat_ready,
  output result_t    o_res,
  output logic       o_res_valid,
  input  logic       i_res_ready
);

  logic [WORD_BITS-1:0] sum_acc;
  logic [WORD_BITS-1:0] xor_acc;
  logic [15:0]          cnt_acc;
  logic [WORD_BITS-1:0] pkt_cnt;          // Packets completed since reset or CLEAR

  logic                 beat_fire;
  logic [WORD_BITS-1:0] add_word;
  logic [WORD_BITS-1:0] sum_next;
  logic [WORD_BITS-1:0] xor_next;
  logic [15:0]          cnt_next;
  status_e              res_status;
  logic [WORD_BITS-1:0] res_value;

  assign o_beat_ready = !(o_res_valid && !i_res_ready);
  assign beat_fire    = i_beat_valid && o_beat_ready;

  // Running values including the current beat
  assign add_word = i_beat.has_data ? i_beat.data : '0;
  assign sum_next = sum_acc + add_word;
  assign xor_next = xor_acc ^ add_word;
  assign cnt_next = cnt_acc + 16'(i_beat.has_data);

  always_comb begin
    res_status = ST_OK;
    res_value  = '0;
    case (opcode_e'(i_beat.opcode))
      OP_SUM:    res_value = sum_next;
      OP_XOR:    res_value = xor_next;
      OP_STATUS: res_value = pkt_cnt;     // Count before this packet
      OP_CLEAR:  res_value = '0;
      default:   res_status = ST_BAD_OPCODE;
    endcase
  end

  always_ff @(posedge i_clk_100) begin
    if (i_rst) begin
      sum_acc     <= '0;
      xor_acc     <= '0;
      cnt_acc     <= '0;
      pkt_cnt     <= '0;
      o_res_valid <= 1'b0;
    end else begin
      if (o_res_valid && i_res_ready)
        o_res_valid <= 1'b0;
      if (beat_fire) begin
        if (i_beat.last) begin
          sum_acc     <= '0;              // Fresh start for next packet
          xor_acc     <= '0;
          cnt_acc     <= '0;
          o_res_valid <= 1'b1;
          if (opcode_e'(i_beat.opcode) == OP_CLEAR)
            pkt_cnt <= '0;
          else
            pkt_cnt <= pkt_cnt + 1'b1;
        end else begin
          sum_acc <= sum_next;
          xor_acc <= xor_next;
          cnt_acc <= cnt_next;
        end
      end
    end
  end

  // Result payload
  always_ff @(posedge i_clk_100) begin
    if (beat_fire && i_beat.last) begin
      o_res.opcode <= i_beat.opcode;
      o_res.tag    <= i_beat.tag;
      o_res.status <= res_status;
      o_res.count  <= cnt_next;
      o_res.value  <= res_value;
    end
  end

endmodule

/* rtl/cmd_parser.sv */
/*
  Packet parser that captures the header word and stamps each payload
  beat with its opcode and tag before handing it to the executor
*/

`timescale 1ns/1ns

module cmd_parser
  import accel_pkg::*;
(
  input  logic         i_clk_100,
  input  logic         i_rst,
  input  stream_word_t i_rx,
  input  logic         i_rx_valid,
  output logic         o_rx_ready,
  output exec_beat_t   o_beat,
  output logic         o_beat_valid,
  input  logic         i_beat_ready
);

  typedef enum logic {
    S_HEADER,
    S_PAYLOAD
  } state_e;

  state_e     state;
  logic [7:0] opcode_q;
  logic [7:0] tag_q;
  logic       rx_fire;

  // One beat of buffering in the output register
  assign o_rx_ready = !(o_beat_valid && !i_beat_ready);
  assign rx_fire    = i_rx_valid && o_rx_ready;

  always_ff @(posedge i_clk_100) begin
    if (i_rst) begin
      state        <= S_HEADER;
      o_beat_valid <= 1'b0;
    end else begin
      if (o_beat_valid && i_beat_ready)
        o_beat_valid <= 1'b0;           // Downstream took it
      if (rx_fire) begin
        case (state)
          S_HEADER: begin
            if (i_rx.last)
              o_beat_valid <= 1'b1;     // Header-only packet
            else
              state <= S_PAYLOAD;
          end
          S_PAYLOAD: begin
            o_beat_valid <= 1'b1;
            if (i_rx.last)
              state <= S_HEADER;
          end
          default: state <= S_HEADER;
        endcase
      end
    end
  end

  // Header fields and output payload
  always_ff @(posedge i_clk_100) begin
    if (rx_fire) begin
      if (state == S_HEADER) begin
        opcode_q        <= i_rx.data[7:0];
        tag_q           <= i_rx.data[15:8];
        // Only seen downstream when the header is also the last beat
        o_beat.opcode   <= i_rx.data[7:0];
        o_beat.tag      <= i_rx.data[15:8];
        o_beat.has_data <= 1'b0;
        o_beat.last     <= 1'b1;
        o_beat.data     <= '0;
      end else begin
        o_beat.opcode   <= opcode_q;
        o_beat.tag      <= tag_q;
        o_beat.has_data <= 1'b1;
        o_beat.last     <= i_rx.last;
        o_beat.data     <= i_rx.data;
      end
    end
  end

endmodule

/* rtl/accel_pkg.sv */
/*
  Shared types for the command engine: stream beat, opcode and status
  enums, and the structs passed between the pipeline stages
*/

package accel_pkg;

  localparam int WORD_BITS = 64;          // Stream data width

  // One beat on the input or output stream
  typedef struct packed {
    logic [WORD_BITS-1:0] data;
    logic                 last;           // Ends the packet
  } stream_word_t;

  // Opcodes carried in header bits 7..0
  typedef enum logic [7:0] {
    OP_STATUS = 8'h01,
    OP_SUM    = 8'h02,
    OP_XOR    = 8'h03,
    OP_CLEAR  = 8'h04
  } opcode_e;

  // Status returned in reply header bits 23..16
  typedef enum logic [7:0] {
    ST_OK         = 8'h00,
    ST_BAD_OPCODE = 8'h01
  } status_e;

  // Parser to executor
  typedef struct packed {
    logic [7:0]           opcode;         // Raw, unknown values pass through
    logic [7:0]           tag;
    logic                 has_data;       // Clear only for a header-only packet
    logic                 last;
    logic [WORD_BITS-1:0] data;
  } exec_beat_t;

  // Executor to reply builder
  typedef struct packed {
    logic [7:0]           opcode;
    logic [7:0]           tag;
    status_e              status;
    logic [15:0]          count;          // Payload words in the packet
    logic [WORD_BITS-1:0] value;
  } result_t;

endpackage
